//--- verilog/pco_pkg.sv
// pco node shared definitions

package pco_pkg;

	// controller FSM states
	typedef enum logic [2:0] {
		IDLE        = 3'd0, // after reset or while disabled
		DESYNC      = 3'd1, // tracking lead and slave resets
		SYNC_LEAD   = 3'd2, // duty window open as lead
		SYNC_SLAVE  = 3'd3, // duty window open as slave
		CHECK_LEAD  = 3'd4, // window closed, recheck lead
		CHECK_SLAVE = 3'd5  // window closed, recheck slave
	} ctrl_state_t;

	// counter fields in the config word, top field first
	typedef enum logic [2:0] {
		F_NDELAY    = 3'd0,
		F_NBLACKOUT = 3'd1,
		F_NCSTR     = 3'd2,
		F_NPCO      = 3'd3,
		F_NDUTYH    = 3'd4,
		F_NDUTYL    = 3'd5,
		F_NPULSE    = 3'd6,
		F_NDUTY     = 3'd7
	} cfg_field_e;

	// width of every pco and controller counter
	localparam int DEFAULT_CNTR_BITS = 13;

	// last index of the encoded sequence, so 16 bits sent
	localparam int DEFAULT_SEQ_LEN = 15;

	// counter fields packed below the encoded sequence
	localparam int NUM_CNTR_FIELDS = 8;

	// pco_en, pulsegen_en, ctrl_en and design_sel at the top
	localparam int NUM_ENABLE_BITS = 4;

endpackage

//--- verilog/pco_config_spi.sv
// serial configuration register

`timescale 1ns/1ps

module pco_config_spi #(
	parameter int CNTR_BITS = pco_pkg::DEFAULT_CNTR_BITS,
	parameter int SEQ_LEN   = pco_pkg::DEFAULT_SEQ_LEN
) (
	input  logic                 clk,
	input  logic                 greset_n,
	input  logic                 spi_din,
	input  logic                 spi_shift,
	input  logic                 spi_load,
	output logic                 spi_dout,
	output logic                 pco_en,
	output logic                 pulsegen_en,
	output logic                 ctrl_en,
	output logic                 design_sel,
	output logic [0:SEQ_LEN]     encoded,
	output logic [CNTR_BITS-1:0] n_delay,
	output logic [CNTR_BITS-1:0] n_blackout,
	output logic [CNTR_BITS-1:0] n_cstr,
	output logic [CNTR_BITS-1:0] n_pco,
	output logic [CNTR_BITS-1:0] n_duty_hi,
	output logic [CNTR_BITS-1:0] n_duty_lo,
	output logic [CNTR_BITS-1:0] n_pulse,
	output logic [CNTR_BITS-1:0] n_duty
);

	localparam int FIELDS_W  = pco_pkg::NUM_CNTR_FIELDS * CNTR_BITS;
	localparam int EN_LSB    = FIELDS_W + SEQ_LEN + 1; // enables sit above the sequence
	localparam int CFG_WIDTH = pco_pkg::NUM_ENABLE_BITS + SEQ_LEN + 1 + FIELDS_W;

	logic [CFG_WIDTH-1:0] shadow_reg; // shifted from spi_din
	logic [CFG_WIDTH-1:0] active_reg; // what the stages see

	// lsb of a counter field, first enum value on top
	function automatic int field_lsb(input pco_pkg::cfg_field_e f);
		return (pco_pkg::NUM_CNTR_FIELDS - 1 - int'(f)) * CNTR_BITS;
	endfunction

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			shadow_reg <= '0;
		end else if (spi_shift) begin
			shadow_reg <= {shadow_reg[CFG_WIDTH-2:0], spi_din}; // first bit ends at msb
		end
	end

	assign spi_dout = shadow_reg[CFG_WIDTH-1]; // oldest bit

	// strobe sampled in clk domain, copy lands on next edge
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			active_reg <= '0;
		end else if (spi_load) begin
			active_reg <= shadow_reg;
		end
	end

	assign pco_en      = active_reg[EN_LSB];
	assign pulsegen_en = active_reg[EN_LSB + 1];
	assign ctrl_en     = active_reg[EN_LSB + 2];
	assign design_sel  = active_reg[EN_LSB + 3];
	assign encoded     = active_reg[FIELDS_W +: SEQ_LEN + 1]; // bit 0 is the high end

	assign n_delay    = active_reg[field_lsb(pco_pkg::F_NDELAY) +: CNTR_BITS];
	assign n_blackout = active_reg[field_lsb(pco_pkg::F_NBLACKOUT) +: CNTR_BITS];
	assign n_cstr     = active_reg[field_lsb(pco_pkg::F_NCSTR) +: CNTR_BITS];
	assign n_pco      = active_reg[field_lsb(pco_pkg::F_NPCO) +: CNTR_BITS];
	assign n_duty_hi  = active_reg[field_lsb(pco_pkg::F_NDUTYH) +: CNTR_BITS];
	assign n_duty_lo  = active_reg[field_lsb(pco_pkg::F_NDUTYL) +: CNTR_BITS];
	assign n_pulse    = active_reg[field_lsb(pco_pkg::F_NPULSE) +: CNTR_BITS];
	assign n_duty     = active_reg[field_lsb(pco_pkg::F_NDUTY) +: CNTR_BITS];

endmodule

//--- verilog/pco_oscillator.sv
// pulse-coupled oscillator

`timescale 1ns/1ps

// progressively slowing trigger counter, period roughly
// ndelay + npco*(npco-1)/2 clocks since cntr_pco starts at 1
module pco_oscillator #(
	parameter int CNTR_BITS = pco_pkg::DEFAULT_CNTR_BITS
) (
	input  logic                 clk,
	input  logic                 greset_n,
	input  logic                 pco_en,
	input  logic                 design_sel,
	input  logic                 peak_in,
	input  logic [CNTR_BITS-1:0] n_delay,
	input  logic [CNTR_BITS-1:0] n_blackout,
	input  logic [CNTR_BITS-1:0] n_cstr,
	input  logic [CNTR_BITS-1:0] n_pco,
	output logic [CNTR_BITS-1:0] cntr_pco,
	output logic                 pco_pulse_out,
	output logic                 pco_pulse_type
);

	localparam logic [CNTR_BITS-1:0] ZERO = '0;
	localparam logic [CNTR_BITS-1:0] ONE  = {{(CNTR_BITS-1){1'b0}}, 1'b1};

	logic [2:0]           peak_sync; // 2 sync flops plus previous sample
	logic [CNTR_BITS-1:0] cntr_del;  // initial delay after each reset
	logic [CNTR_BITS-1:0] cntr_trig; // spacing between trigger ticks
	logic [CNTR_BITS:0]   coupled_sum; // one extra bit, no wrap
	logic                 cpulse;
	logic                 cpulse_rst;
	logic                 trig_en;
	logic                 trig_clk;
	logic                 trig_rst;
	logic                 pco_rst;

	// rising edge of synced peak, ignored inside blackout
	assign cpulse      = peak_sync[1] && !peak_sync[2] && (cntr_pco > n_blackout);
	assign coupled_sum = {1'b0, cntr_pco} + {1'b0, n_cstr};
	assign cpulse_rst  = coupled_sum >= {1'b0, n_pco};

	assign trig_en  = (cntr_del == n_delay);
	assign trig_clk = ((cntr_trig + ONE) == cntr_pco) && trig_en; // slows as phase grows
	assign trig_rst = (cntr_pco + ONE) == n_pco;

	// forced reset wins over overflow in the same cycle
	assign pco_rst        = pco_en && ((cpulse && cpulse_rst) || (trig_clk && trig_rst));
	assign pco_pulse_out  = pco_rst;
	assign pco_pulse_type = pco_en && cpulse && cpulse_rst;

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			peak_sync <= 3'b000;
		end else if (pco_en) begin
			peak_sync <= {peak_sync[1:0], peak_in};
		end
	end

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cntr_del <= ZERO;
		end else if (pco_rst) begin
			cntr_del <= (design_sel && pco_pulse_type) ? ONE : ZERO; // shorter delay when coupled
		end else if (pco_en && (cntr_del != n_delay)) begin
			cntr_del <= cntr_del + ONE;
		end
	end

	always_ff @(posedge clk) begin
		if (!greset_n || pco_rst) begin
			cntr_trig <= ZERO;
		end else if (pco_en) begin
			if ((cntr_trig + ONE) == cntr_pco) begin
				cntr_trig <= ZERO; // wrap at current phase
			end else begin
				cntr_trig <= cntr_trig + ONE;
			end
		end
	end

	// phase counter
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cntr_pco <= ONE;
		end else if (pco_en) begin
			if (cpulse) begin
				if (cpulse_rst) begin
					cntr_pco <= ONE; // forced by neighbour
				end else begin
					cntr_pco <= coupled_sum[CNTR_BITS-1:0]; // jump by coupling strength
				end
			end else if (trig_clk) begin
				if (trig_rst) begin
					cntr_pco <= ONE; // natural overflow
				end else begin
					cntr_pco <= cntr_pco + ONE;
				end
			end
		end
	end

endmodule

//--- verilog/duty_controller.sv
// duty cycling controller

`timescale 1ns/1ps

// natural reset -> lead candidate
// late forced reset (after ndutyh) -> slave candidate
// early forced reset -> probably a stray node, start over
module duty_controller #(
	parameter int CNTR_BITS = pco_pkg::DEFAULT_CNTR_BITS
) (
	input  logic                  clk,
	input  logic                  greset_n,
	input  logic                  ctrl_en,
	input  logic                  pco_pulse_out,
	input  logic                  pco_pulse_type,
	input  logic [CNTR_BITS-1:0]  cntr_pco,
	input  logic [CNTR_BITS-1:0]  n_duty_hi,
	input  logic [CNTR_BITS-1:0]  n_duty_lo,
	input  logic [CNTR_BITS-1:0]  n_pulse,
	input  logic [CNTR_BITS-1:0]  n_duty,
	output logic                  duty_out,
	output pco_pkg::ctrl_state_t  ctrl_state
);

	localparam logic [CNTR_BITS-1:0] ZERO = '0;
	localparam logic [CNTR_BITS-1:0] ONE  = {{(CNTR_BITS-1){1'b0}}, 1'b1};

	pco_pkg::ctrl_state_t next_state;
	logic [CNTR_BITS-1:0] cnt_lead;  // natural resets seen
	logic [CNTR_BITS-1:0] cnt_slave; // late forced resets seen
	logic [CNTR_BITS-1:0] cnt_duty;  // pulses spent synchronized
	logic                 natural_rst;
	logic                 forced_rst;
	logic                 synchronized;
	logic                 in_window;
	logic                 clr_track;
	logic                 clr_duty;

	assign natural_rst  = pco_pulse_out && !pco_pulse_type;
	assign forced_rst   = pco_pulse_out && pco_pulse_type;
	assign synchronized = (ctrl_state == pco_pkg::SYNC_LEAD) ||
		(ctrl_state == pco_pkg::SYNC_SLAVE);
	assign in_window    = (cntr_pco >= n_duty_lo) && (cntr_pco <= n_duty_hi);

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			duty_out <= 1'b0;
		end else if (ctrl_en) begin
			duty_out <= in_window && synchronized; // one cycle behind the compare
		end
	end

	// reset tracker
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cnt_lead  <= ZERO;
			cnt_slave <= ZERO;
		end else if (ctrl_en) begin
			if (clr_track) begin
				cnt_lead  <= ZERO;
				cnt_slave <= ZERO;
			end else if (forced_rst) begin
				if (cntr_pco <= n_duty_hi) begin
					cnt_lead  <= ZERO; // premature, drop both
					cnt_slave <= ZERO;
				end else begin
					cnt_slave <= cnt_slave + ONE; // faster neighbour
				end
			end else if (natural_rst) begin
				cnt_lead <= cnt_lead + ONE; // fastest or alone
			end
		end
	end

	// duty duration, stops at n_duty
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cnt_duty <= ZERO;
		end else if (ctrl_en) begin
			if (clr_duty) begin
				cnt_duty <= ZERO;
			end else if (pco_pulse_out && synchronized && (cnt_duty < n_duty)) begin
				cnt_duty <= cnt_duty + ONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			ctrl_state <= pco_pkg::IDLE;
		end else if (ctrl_en) begin
			ctrl_state <= next_state;
		end
	end

	always_comb begin
		next_state = ctrl_state;
		clr_track  = 1'b0;
		clr_duty   = 1'b0;
		case (ctrl_state)
			pco_pkg::IDLE: begin
				next_state = pco_pkg::DESYNC;
				clr_track  = 1'b1;
			end
			pco_pkg::DESYNC: begin
				if (cnt_lead == n_pulse) begin
					next_state = pco_pkg::SYNC_LEAD;
					clr_duty   = 1'b1;
				end else if (cnt_slave == n_pulse) begin
					next_state = pco_pkg::SYNC_SLAVE;
					clr_duty   = 1'b1;
				end
			end
			pco_pkg::SYNC_LEAD: begin
				if (cnt_duty >= n_duty) begin
					next_state = pco_pkg::CHECK_LEAD;
				end
			end
			pco_pkg::SYNC_SLAVE: begin
				if (cnt_duty >= n_duty) begin
					next_state = pco_pkg::CHECK_SLAVE;
				end
			end
			pco_pkg::CHECK_LEAD: begin
				if (natural_rst) begin
					next_state = pco_pkg::SYNC_LEAD; // still leading
					clr_duty   = 1'b1;
				end else if (forced_rst) begin
					next_state = pco_pkg::DESYNC;
					clr_track  = 1'b1;
				end
			end
			pco_pkg::CHECK_SLAVE: begin
				if (forced_rst) begin
					next_state = pco_pkg::SYNC_SLAVE; // still following
					clr_duty   = 1'b1;
				end else if (natural_rst) begin
					next_state = pco_pkg::DESYNC;
					clr_track  = 1'b1;
				end
			end
			default: begin
				next_state = pco_pkg::IDLE;
			end
		endcase
	end

endmodule

//--- verilog/sequence_pulsegen.sv
// coding sequence pulse generator

`timescale 1ns/1ps

module sequence_pulsegen #(
	parameter int SEQ_LEN = pco_pkg::DEFAULT_SEQ_LEN
) (
	input  logic             clk,
	input  logic             greset_n,
	input  logic             pulsegen_en,
	input  logic             pco_pulse_out,
	input  logic [0:SEQ_LEN] encoded,
	output logic             pulsegen_out
);

	localparam int IDX_BITS = $clog2(SEQ_LEN + 1);
	localparam logic [IDX_BITS-1:0] FIRST = '0;
	localparam logic [IDX_BITS-1:0] LAST  = IDX_BITS'(SEQ_LEN);
	localparam logic [IDX_BITS-1:0] STEP  = {{(IDX_BITS-1){1'b0}}, 1'b1};

	logic [IDX_BITS-1:0] bit_idx; // rests at LAST when idle

	assign pulsegen_out = encoded[bit_idx]; // last bit held while idle

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			bit_idx <= LAST;
		end else if (pulsegen_en) begin
			if (pco_pulse_out && (bit_idx == LAST)) begin
				bit_idx <= FIRST; // start only from idle
			end else if (bit_idx < LAST) begin
				bit_idx <= bit_idx + STEP;
			end
		end
	end

endmodule

//--- verilog/pco_node_top.sv
// pco node top level

`timescale 1ns/1ps

module pco_node_top #(
	parameter int CNTR_BITS = pco_pkg::DEFAULT_CNTR_BITS,
	parameter int SEQ_LEN   = pco_pkg::DEFAULT_SEQ_LEN
) (
	input  logic                 clk,
	input  logic                 greset_n,
	input  logic                 spi_din,
	input  logic                 spi_shift,
	input  logic                 spi_load,
	input  logic                 peak_in,
	output logic                 spi_dout,
	output logic [CNTR_BITS-1:0] cntr_pco,
	output logic                 pco_pulse_out,
	output logic                 pco_pulse_type,
	output logic                 duty_out,
	output pco_pkg::ctrl_state_t ctrl_state,
	output logic                 pulsegen_out
);

	// enables and fields from the active register
	logic                 pco_en;
	logic                 pulsegen_en;
	logic                 ctrl_en;
	logic                 design_sel;
	logic [0:SEQ_LEN]     encoded;
	logic [CNTR_BITS-1:0] n_delay;
	logic [CNTR_BITS-1:0] n_blackout;
	logic [CNTR_BITS-1:0] n_cstr;
	logic [CNTR_BITS-1:0] n_pco;
	logic [CNTR_BITS-1:0] n_duty_hi;
	logic [CNTR_BITS-1:0] n_duty_lo;
	logic [CNTR_BITS-1:0] n_pulse;
	logic [CNTR_BITS-1:0] n_duty;

	pco_config_spi #(.CNTR_BITS(CNTR_BITS), .SEQ_LEN(SEQ_LEN)) i_config (
		.clk(clk), .greset_n(greset_n),
		.spi_din(spi_din), .spi_shift(spi_shift), .spi_load(spi_load), .spi_dout(spi_dout),
		.pco_en(pco_en), .pulsegen_en(pulsegen_en), .ctrl_en(ctrl_en),
		.design_sel(design_sel), .encoded(encoded),
		.n_delay(n_delay), .n_blackout(n_blackout), .n_cstr(n_cstr), .n_pco(n_pco),
		.n_duty_hi(n_duty_hi), .n_duty_lo(n_duty_lo), .n_pulse(n_pulse), .n_duty(n_duty)
	);

	pco_oscillator #(.CNTR_BITS(CNTR_BITS)) i_oscillator (
		.clk(clk), .greset_n(greset_n),
		.pco_en(pco_en), .design_sel(design_sel), .peak_in(peak_in),
		.n_delay(n_delay), .n_blackout(n_blackout), .n_cstr(n_cstr), .n_pco(n_pco),
		.cntr_pco(cntr_pco), .pco_pulse_out(pco_pulse_out), .pco_pulse_type(pco_pulse_type)
	);

	duty_controller #(.CNTR_BITS(CNTR_BITS)) i_controller (
		.clk(clk), .greset_n(greset_n), .ctrl_en(ctrl_en),
		.pco_pulse_out(pco_pulse_out), .pco_pulse_type(pco_pulse_type), .cntr_pco(cntr_pco),
		.n_duty_hi(n_duty_hi), .n_duty_lo(n_duty_lo), .n_pulse(n_pulse), .n_duty(n_duty),
		.duty_out(duty_out), .ctrl_state(ctrl_state)
	);

	// every pco reset tries to start a sequence
	sequence_pulsegen #(.SEQ_LEN(SEQ_LEN)) i_pulsegen (
		.clk(clk), .greset_n(greset_n), .pulsegen_en(pulsegen_en),
		.pco_pulse_out(pco_pulse_out), .encoded(encoded), .pulsegen_out(pulsegen_out)
	);

endmodule

//--- verification/pco_node_chk.sv
// duty controller assertions

`timescale 1ns/1ps

module pco_node_chk #(
	parameter int CNTR_BITS = pco_pkg::DEFAULT_CNTR_BITS
) (
	input logic                 clk,
	input logic                 greset_n,
	input logic                 ctrl_en,
	input logic                 duty_out,
	input pco_pkg::ctrl_state_t ctrl_state,
	input logic [CNTR_BITS-1:0] cnt_lead,
	input logic [CNTR_BITS-1:0] cnt_slave,
	input logic [CNTR_BITS-1:0] cnt_duty
);

	// window opens only one cycle after a sync state
	duty_rise_from_sync: assert property (@(posedge clk) disable iff (!greset_n)
		$rose(duty_out) |-> ($past(ctrl_state) == pco_pkg::SYNC_LEAD ||
			$past(ctrl_state) == pco_pkg::SYNC_SLAVE))
		else $error("duty_out rose while the previous state was not a sync state");

	state_legal: assert property (@(posedge clk) disable iff (!greset_n)
		ctrl_state <= pco_pkg::CHECK_SLAVE)
		else $error("controller state left the legal range");

	// tracker and duty counters frozen while disabled
	hold_when_disabled: assert property (@(posedge clk) disable iff (!greset_n)
		!ctrl_en |=> ($stable(cnt_lead) && $stable(cnt_slave) && $stable(cnt_duty)))
		else $error("controller counter moved while ctrl_en was low");

endmodule

bind duty_controller pco_node_chk #(.CNTR_BITS(CNTR_BITS)) i_chk (
	.clk(clk), .greset_n(greset_n), .ctrl_en(ctrl_en), .duty_out(duty_out),
	.ctrl_state(ctrl_state), .cnt_lead(cnt_lead), .cnt_slave(cnt_slave), .cnt_duty(cnt_duty)
);

//--- verification/pco_node_monitor.sv
// pco node response monitor

`timescale 1ns/1ps

module pco_node_monitor #(
	parameter int CNTR_BITS = pco_pkg::DEFAULT_CNTR_BITS,
	parameter int SEQ_LEN   = pco_pkg::DEFAULT_SEQ_LEN
) (
	input  logic                 clk,
	input  logic                 greset_n,
	input  logic                 spi_din,
	input  logic                 spi_shift,
	input  logic                 spi_dout,
	input  logic                 peak_in,
	input  logic [CNTR_BITS-1:0] cntr_pco,
	input  logic                 pco_pulse_out,
	input  logic                 pco_pulse_type,
	input  logic                 duty_out,
	input  pco_pkg::ctrl_state_t ctrl_state,
	input  logic                 pulsegen_out,
	input  logic                 cfg_loaded,
	input  logic [1:0]           phase,   // 1 free run, 2 peaks
	input  logic [SEQ_LEN:0]     exp_seq, // msb is sequence bit 0
	input  int                   n_delay,
	input  int                   n_blackout,
	input  int                   n_cstr,
	input  int                   n_pco,
	input  int                   n_duty_hi,
	input  int                   n_duty_lo,
	input  int                   n_pulse,
	input  int                   n_duty,
	output int                   error_count,
	output int                   check_count
);

	localparam int CFG_WIDTH = pco_pkg::NUM_ENABLE_BITS + SEQ_LEN + 1 +
		pco_pkg::NUM_CNTR_FIELDS * CNTR_BITS;

	logic shift_q[$]; // bits still inside the shadow register
	logic prev_rst_n = 1'b0;
	logic prev_peak = 1'b0;
	logic exp_duty = 1'b0; // window compare from last cycle
	pco_pkg::ctrl_state_t prev_state = pco_pkg::IDLE;
	int cyc = 0;
	int pco;
	int gap;
	int last_pulse = -1;
	int first_gap = 0;
	int peak_age = 0;  // cycles since peak_in rose
	int peak_pco = 0;
	int nat_streak = 0;
	int slave_streak = 0;
	int sync_pulses = 0;
	int seq_pos = SEQ_LEN;

	initial begin
		error_count = 0;
		check_count = 0;
	end

	task check(input bit ok, input string msg);
		check_count++;
		if (!ok) begin
			error_count++;
			$display("FAILED at %0t ns: %s", $time, msg);
		end
	endtask

	function automatic bit is_sync(input pco_pkg::ctrl_state_t s);
		return (s == pco_pkg::SYNC_LEAD) || (s == pco_pkg::SYNC_SLAVE);
	endfunction

	always @(posedge clk) begin
		cyc++;
		pco = int'(cntr_pco);
		if (!greset_n) begin
			shift_q.delete();
			exp_duty = 1'b0;
			peak_age = 0;
			seq_pos = SEQ_LEN;
		end else begin
			if (!prev_rst_n) begin
				check(!duty_out, "duty_out not 0 after reset");
				check(ctrl_state == pco_pkg::IDLE, "state not IDLE after reset");
				check(pco == 1, $sformatf("cntr_pco %0d after reset, expected 1", pco));
			end
			// a bit leaves CFG_WIDTH shifts after it entered
			if (spi_shift) begin
				if (shift_q.size() == CFG_WIDTH) begin
					check(spi_dout == shift_q[0], "spi_dout echo bit differs from bit shifted in");
					void'(shift_q.pop_front());
				end
				shift_q.push_back(spi_din);
			end
			if (pco_pulse_out && phase == 2'd1) begin
				check(!pco_pulse_type, "forced pulse while no peaks were sent");
				if (last_pulse >= 0) begin
					gap = cyc - last_pulse;
					check(gap >= n_delay && gap <= n_delay + n_pco * (n_pco + 1) / 2,
						$sformatf("pulse interval %0d out of bounds", gap));
					if (first_gap == 0) begin
						first_gap = gap;
					end else begin
						check(gap == first_gap, $sformatf("interval %0d, expected %0d", gap, first_gap));
					end
				end
				last_pulse = cyc;
			end
			// peak effect two edges after it is sampled
			if (peak_age == 2) begin
				peak_pco = pco;
				if (pco > n_blackout && pco + n_cstr >= n_pco) begin
					check(pco_pulse_out && pco_pulse_type, "peak outside blackout gave no forced pulse");
				end else if (pco <= n_blackout) begin
					check(!pco_pulse_out, "peak inside blackout caused a pulse");
				end
			end else if (peak_age == 3) begin
				if (peak_pco <= n_blackout) begin
					check(pco == peak_pco || pco == peak_pco + 1, "cntr_pco jumped after blackout peak");
				end else if (peak_pco + n_cstr < n_pco) begin
					check(pco == peak_pco + n_cstr, "cntr_pco did not advance by ncstr");
				end
			end
			if (phase == 2'd2 && peak_in && !prev_peak) peak_age = 1;
			else if (peak_age > 0 && peak_age < 3) peak_age++;
			else peak_age = 0;
			check(duty_out == exp_duty, $sformatf("duty_out %0b, expected %0b", duty_out, exp_duty));
			exp_duty = is_sync(ctrl_state) && pco >= n_duty_lo && pco <= n_duty_hi;
			// sync entry and duty length
			if (prev_state == pco_pkg::DESYNC && ctrl_state == pco_pkg::SYNC_LEAD)
				check(nat_streak >= n_pulse, "SYNC_LEAD without enough natural resets");
			if (prev_state == pco_pkg::DESYNC && ctrl_state == pco_pkg::SYNC_SLAVE)
				check(slave_streak >= n_pulse, "SYNC_SLAVE without enough late forced resets");
			if (prev_state == pco_pkg::SYNC_LEAD && ctrl_state != pco_pkg::SYNC_LEAD)
				check(ctrl_state == pco_pkg::CHECK_LEAD && sync_pulses == n_duty,
					$sformatf("left SYNC_LEAD after %0d pulses", sync_pulses));
			if (prev_state == pco_pkg::SYNC_SLAVE && ctrl_state != pco_pkg::SYNC_SLAVE)
				check(ctrl_state == pco_pkg::CHECK_SLAVE && sync_pulses == n_duty,
					$sformatf("left SYNC_SLAVE after %0d pulses", sync_pulses));
			if (is_sync(ctrl_state)) begin
				if (!is_sync(prev_state)) sync_pulses = 0;
				if (pco_pulse_out) sync_pulses++;
			end
			if (pco_pulse_out) begin
				if (!pco_pulse_type) begin
					nat_streak++;
					slave_streak = 0;
				end else if (pco > n_duty_hi) begin
					slave_streak++; // late, following a neighbour
					nat_streak = 0;
				end else begin
					nat_streak = 0;
					slave_streak = 0;
				end
			end
			if (cfg_loaded) begin
				check(pulsegen_out == exp_seq[SEQ_LEN - seq_pos],
					$sformatf("pulsegen_out wrong at sequence bit %0d", seq_pos));
				if (pco_pulse_out && seq_pos == SEQ_LEN) seq_pos = 0; // start only when idle
				else if (seq_pos < SEQ_LEN) seq_pos++;
			end
		end
		prev_rst_n = greset_n;
		prev_peak = peak_in;
		prev_state = ctrl_state;
	end

endmodule

//--- verification/tb_pco_node.sv
// pco node testbench

`timescale 1ns/1ps

module tb_pco_node;

	localparam int CB = pco_pkg::DEFAULT_CNTR_BITS;
	localparam int SL = pco_pkg::DEFAULT_SEQ_LEN;
	localparam int NF = pco_pkg::NUM_CNTR_FIELDS;
	localparam int CFG_WIDTH = pco_pkg::NUM_ENABLE_BITS + SL + 1 + NF * CB;
	localparam int WAIT_LIMIT = 2000; // cycles per wait
	localparam int SLAVE_TRIES = 12;

	logic clk = 1'b0;
	logic greset_n;
	logic spi_din;
	logic spi_shift;
	logic spi_load;
	logic peak_in;
	logic spi_dout;
	logic [CB-1:0] cntr_pco;
	logic pco_pulse_out;
	logic pco_pulse_type;
	logic duty_out;
	pco_pkg::ctrl_state_t ctrl_state;
	logic pulsegen_out;
	logic cfg_loaded;
	logic [1:0] phase;
	logic [31:0] stim [0:13];
	logic [CFG_WIDTH-1:0] cfg_word;
	logic [SL:0] exp_seq;
	logic [31:0] lcg_state;
	int cfg_val [0:NF-1];
	int error_count;
	int check_count;
	bit timed_out;

	always #10 clk = ~clk; // 20 ns period

	pco_node_top #(.CNTR_BITS(CB), .SEQ_LEN(SL)) i_pco_node_top (
		.clk(clk), .greset_n(greset_n), .spi_din(spi_din), .spi_shift(spi_shift),
		.spi_load(spi_load), .peak_in(peak_in), .spi_dout(spi_dout), .cntr_pco(cntr_pco),
		.pco_pulse_out(pco_pulse_out), .pco_pulse_type(pco_pulse_type), .duty_out(duty_out),
		.ctrl_state(ctrl_state), .pulsegen_out(pulsegen_out)
	);

	pco_node_monitor #(.CNTR_BITS(CB), .SEQ_LEN(SL)) i_monitor (
		.clk(clk), .greset_n(greset_n), .spi_din(spi_din), .spi_shift(spi_shift),
		.spi_dout(spi_dout), .peak_in(peak_in), .cntr_pco(cntr_pco),
		.pco_pulse_out(pco_pulse_out), .pco_pulse_type(pco_pulse_type), .duty_out(duty_out),
		.ctrl_state(ctrl_state), .pulsegen_out(pulsegen_out), .cfg_loaded(cfg_loaded),
		.phase(phase), .exp_seq(exp_seq),
		.n_delay(cfg_val[pco_pkg::F_NDELAY]), .n_blackout(cfg_val[pco_pkg::F_NBLACKOUT]),
		.n_cstr(cfg_val[pco_pkg::F_NCSTR]), .n_pco(cfg_val[pco_pkg::F_NPCO]),
		.n_duty_hi(cfg_val[pco_pkg::F_NDUTYH]), .n_duty_lo(cfg_val[pco_pkg::F_NDUTYL]),
		.n_pulse(cfg_val[pco_pkg::F_NPULSE]), .n_duty(cfg_val[pco_pkg::F_NDUTY]),
		.error_count(error_count), .check_count(check_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// msb first, one bit per falling edge
	task automatic shift_word(input logic [CFG_WIDTH-1:0] w);
		for (int i = CFG_WIDTH - 1; i >= 0; i--) begin
			@(negedge clk);
			spi_shift = 1'b1;
			spi_din = w[i];
		end
		@(negedge clk);
		spi_shift = 1'b0;
		spi_din = 1'b0;
	endtask

	task automatic wait_state(input pco_pkg::ctrl_state_t s);
		int n;
		n = 0;
		while (ctrl_state != s && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (ctrl_state != s) begin
			$display("timeout: controller never reached state %s", s.name());
			timed_out = 1'b1;
		end
	endtask

	// raise peak_in once cntr_pco hits the target phase
	task automatic send_peak(input int target);
		int n;
		int hold;
		n = 0;
		@(negedge clk);
		while (int'(cntr_pco) != target && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (int'(cntr_pco) != target) begin
			$display("timeout: oscillator phase %0d never seen", target);
			timed_out = 1'b1;
		end else begin
			lcg_state = lcg_next(lcg_state);
			hold = 2 + int'(lcg_state[17:16]); // random peak width
			peak_in = 1'b1;
			repeat (hold) @(negedge clk);
			peak_in = 1'b0;
			repeat (4) @(negedge clk);
		end
	endtask

	initial begin
		int tries;
		greset_n = 1'b0;
		spi_din = 1'b0;
		spi_shift = 1'b0;
		spi_load = 1'b0;
		peak_in = 1'b0;
		cfg_loaded = 1'b0;
		phase = 2'd0;
		timed_out = 1'b0;
		lcg_state = 32'h8ddb8f37;
		$readmemh("verification/pco_node_stimulus.txt", stim);
		exp_seq = stim[9][SL:0];
		cfg_word = '0;
		cfg_word[CFG_WIDTH-1 -: 4] = stim[8][3:0];
		cfg_word[NF*CB +: SL+1] = exp_seq;
		for (int i = 0; i < NF; i++) begin
			cfg_val[i] = int'(stim[i][CB-1:0]); // file order is cfg_field_e
			cfg_word[(NF-1-i)*CB +: CB] = stim[i][CB-1:0];
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		greset_n = 1'b1;
		shift_word(cfg_word);
		spi_load = 1'b1;
		@(negedge clk);
		spi_load = 1'b0;
		cfg_loaded = 1'b1;
		phase = 2'd1;
		shift_word(cfg_word); // second pass echoes the first
		wait_state(pco_pkg::CHECK_LEAD);
		if (!timed_out) begin
			phase = 2'd2;
			for (int k = 0; k < int'(stim[10]); k++) begin
				if (!timed_out) send_peak(int'(stim[11+k]));
			end
		end
		tries = 0;
		while (!timed_out && ctrl_state != pco_pkg::SYNC_SLAVE && tries < SLAVE_TRIES) begin
			send_peak(int'(stim[10 + int'(stim[10])]));
			tries++;
		end
		if (!timed_out && ctrl_state != pco_pkg::SYNC_SLAVE) begin
			$display("slave synchronization not reached after repeated peaks");
			timed_out = 1'b1;
		end
		repeat (40) @(negedge clk); // let the last sequence finish
		$display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timed_out);
		if (error_count == 0 && !timed_out) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verification/pco_node_stimulus.txt
// config and peak script, one hex word per line: 0-7 counter fields in cfg_field_e order,
// 8 enables {design_sel,ctrl_en,pulsegen_en,pco_en}, 9 encoded bits (msb first), 10 peak count, then peak phases
0004
0003
0004
0008
0006
0002
0003
0002
7
b3a5
3
1
2
7

//--- verilog.f
verilog/pco_pkg.sv
verilog/pco_config_spi.sv
verilog/pco_oscillator.sv
verilog/duty_controller.sv
verilog/sequence_pulsegen.sv
verilog/pco_node_top.sv
verification/pco_node_chk.sv
verification/pco_node_monitor.sv
verification/tb_pco_node.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pco_node -f verilog.f -o sim_pco_node
./obj_dir/sim_pco_node | tee sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
	exit 0
fi
exit 1
